/* hdl/gnn_pkg.sv */
// gnn aggregation constants
package gnn_pkg;

    // engine sizing
    localparam int num_edge_pe = 4;
    localparam int pe_idx_w    = 2;          // response tag width
    localparam int node_id_w   = 6;
    localparam int max_nodes   = 64;
    localparam int node_cnt_w  = 7;          // holds 0..64
    localparam int nbr_addr_w  = 8;          // 256 neighbor slots
    localparam int deg_w       = 4;          // degree 0..15
    localparam int entry_w     = nbr_addr_w + deg_w;   // {start, degree}
    localparam int fv_w        = 16;
    localparam int weight_w    = 8;
    localparam int sum_w       = 20;         // 15 * 0xffff fits
    localparam int res_w       = 28;         // sum * weight

    // word-addressed wishbone bus
    localparam int wb_addr_w = 12;
    localparam int wb_data_w = 32;

    // control registers
    localparam logic [wb_addr_w-1:0] reg_ctrl      = 12'h000;  // bit 0 start
    localparam logic [wb_addr_w-1:0] reg_status    = 12'h001;  // bit 0 busy, bit 1 done
    localparam logic [wb_addr_w-1:0] reg_num_nodes = 12'h002;
    localparam logic [wb_addr_w-1:0] reg_weight    = 12'h003;

    // memory regions decoded on adr[11:8]
    localparam logic [wb_addr_w-1:0] base_node = 12'h100;  // bits 11:4 start, 3:0 degree
    localparam logic [wb_addr_w-1:0] base_nbr  = 12'h200;  // neighbor id
    localparam logic [wb_addr_w-1:0] base_fv   = 12'h300;  // feature value
    localparam logic [wb_addr_w-1:0] base_res  = 12'h400;  // results, read only

    // memory access kinds
    localparam logic acc_node = 1'b0;  // table entry read
    localparam logic acc_nbr  = 1'b1;  // neighbor id then its feature

endpackage

/* hdl/rr_arbiter.sv */
// round robin arbiter
`timescale 1ns/1ps
module rr_arbiter #(
    parameter int num_reqs = 4
) (
    input  logic                clk,
    input  logic                arst_n,
    input  logic [num_reqs-1:0] reqs,
    output logic [num_reqs-1:0] grants
);

    logic [$clog2(num_reqs)-1:0] last_q;  // last granted requester
    logic [$clog2(num_reqs)-1:0] win;

    // search starts one past the last winner
    always_comb begin
        int idx;
        grants = '0;
        win    = last_q;
        for (int k = 1; k <= num_reqs; k++) begin
            idx = (int'(last_q) + k) % num_reqs;
            if (reqs[idx] && grants == '0) begin
                grants[idx] = 1'b1;  // first hit only, one-hot
                win         = idx[$clog2(num_reqs)-1:0];
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            last_q <= '0;
        end else if (|reqs) begin
            last_q <= win;  // rotate priority after each grant
        end
    end

endmodule

/* hdl/gnn_regs.sv */
// wishbone register block
`timescale 1ns/1ps
module gnn_regs (
    input  logic                                                clk,
    input  logic                                                arst_n,
    input  logic                                                cyc,
    input  logic                                                stb,
    input  logic                                                we,
    input  logic [gnn_pkg::wb_addr_w-1:0]                       adr,
    input  logic [gnn_pkg::wb_data_w-1:0]                       dat_w,
    input  logic [gnn_pkg::num_edge_pe-1:0]                     wb_gnt,
    input  logic [gnn_pkg::num_edge_pe*gnn_pkg::node_id_w-1:0]  all_wb_node,
    input  logic [gnn_pkg::num_edge_pe*gnn_pkg::res_w-1:0]      all_wb_result,
    input  logic                                                done_in,
    output logic [gnn_pkg::wb_data_w-1:0]                       dat_r,
    output logic                                                ack,
    output logic                                                start,
    output logic [gnn_pkg::node_cnt_w-1:0]                      num_nodes,
    output logic [gnn_pkg::weight_w-1:0]                        weight,
    output logic                                                busy,
    output logic                                                host_we,
    output logic [1:0]                                          host_sel,
    output logic [gnn_pkg::nbr_addr_w-1:0]                      host_addr,
    output logic [gnn_pkg::fv_w-1:0]                            host_data
);

    logic [gnn_pkg::res_w-1:0]     res_mem [gnn_pkg::max_nodes];  // result array
    logic [3:0]                    rgn;      // region code
    logic                          wr;       // write in its ack cycle
    logic                          done_q;
    logic [gnn_pkg::wb_data_w-1:0] rd_data;

    assign rgn = adr[11:8];
    assign wr  = ack & we;

    assign start = wr && (adr == gnn_pkg::reg_ctrl) && dat_w[0];  // one-cycle pulse

    // graph regions go straight to graph_mem
    assign host_we   = wr && (rgn == gnn_pkg::base_node[11:8] ||
                              rgn == gnn_pkg::base_nbr[11:8]  ||
                              rgn == gnn_pkg::base_fv[11:8]);
    assign host_sel  = adr[9:8];  // low bits of region code
    assign host_addr = adr[gnn_pkg::nbr_addr_w-1:0];
    assign host_data = dat_w[gnn_pkg::fv_w-1:0];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ack       <= 1'b0;
            busy      <= 1'b0;
            done_q    <= 1'b0;
            num_nodes <= '0;
            weight    <= '0;
        end else begin
            ack <= cyc & stb & ~ack;  // single pulse one cycle after the request
            if (start) begin
                busy   <= 1'b1;
                done_q <= 1'b0;
            end else if (done_in && busy) begin
                busy   <= 1'b0;  // run finished
                done_q <= 1'b1;  // sticky until next start
            end
            if (wr && adr == gnn_pkg::reg_num_nodes) begin
                num_nodes <= dat_w[gnn_pkg::node_cnt_w-1:0];
            end
            if (wr && adr == gnn_pkg::reg_weight) begin
                weight <= dat_w[gnn_pkg::weight_w-1:0];
            end
        end
    end

    // ctrl and write-only regions read as 0
    always_comb begin
        rd_data = '0;
        if (adr == gnn_pkg::reg_status) begin
            rd_data[1:0] = {done_q, busy};
        end else if (adr == gnn_pkg::reg_num_nodes) begin
            rd_data[gnn_pkg::node_cnt_w-1:0] = num_nodes;
        end else if (adr == gnn_pkg::reg_weight) begin
            rd_data[gnn_pkg::weight_w-1:0] = weight;
        end else if (rgn == gnn_pkg::base_res[11:8] && adr[7:6] == 2'b00) begin
            rd_data[gnn_pkg::res_w-1:0] = res_mem[adr[gnn_pkg::node_id_w-1:0]];
        end
    end

    always_ff @(posedge clk) begin
        dat_r <= rd_data;  // valid alongside ack
    end

    // granted PE result lands in the grant cycle
    always_ff @(posedge clk) begin
        for (int i = 0; i < gnn_pkg::num_edge_pe; i++) begin
            if (wb_gnt[i]) begin
                res_mem[all_wb_node[i*gnn_pkg::node_id_w +: gnn_pkg::node_id_w]] <=
                    all_wb_result[i*gnn_pkg::res_w +: gnn_pkg::res_w];
            end
        end
    end

endmodule

/* hdl/graph_mem.sv */
// graph memories with tagged read pipe
`timescale 1ns/1ps
module graph_mem (
    input  logic                           clk,
    input  logic                           arst_n,
    input  logic                           host_we,
    input  logic [1:0]                     host_sel,
    input  logic [gnn_pkg::nbr_addr_w-1:0] host_addr,
    input  logic [gnn_pkg::fv_w-1:0]       host_data,
    input  logic                           rd_en,
    input  logic                           rd_kind,
    input  logic [gnn_pkg::nbr_addr_w-1:0] rd_addr,
    input  logic [gnn_pkg::pe_idx_w-1:0]   rd_tag,
    output logic                           rsp_valid,
    output logic [gnn_pkg::pe_idx_w-1:0]   rsp_tag,
    output logic [gnn_pkg::fv_w-1:0]       rsp_data
);

    logic [gnn_pkg::entry_w-1:0]   node_tab [gnn_pkg::max_nodes];
    logic [gnn_pkg::node_id_w-1:0] nbr_list [2**gnn_pkg::nbr_addr_w];
    logic [gnn_pkg::fv_w-1:0]      feat     [gnn_pkg::max_nodes];

    logic                         s1_valid;
    logic                         s1_kind;
    logic [gnn_pkg::pe_idx_w-1:0] s1_tag;
    logic [gnn_pkg::fv_w-1:0]     s1_data;  // table entry or neighbor id

    // host load port
    always_ff @(posedge clk) begin
        if (host_we) begin
            case (host_sel)
                gnn_pkg::base_node[9:8]:
                    node_tab[host_addr[gnn_pkg::node_id_w-1:0]] <=
                        host_data[gnn_pkg::entry_w-1:0];
                gnn_pkg::base_nbr[9:8]:
                    nbr_list[host_addr] <= host_data[gnn_pkg::node_id_w-1:0];
                gnn_pkg::base_fv[9:8]:
                    feat[host_addr[gnn_pkg::node_id_w-1:0]] <= host_data;
                default: ;
            endcase
        end
    end

    // valid bits walk the two stages
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            s1_valid  <= 1'b0;
            rsp_valid <= 1'b0;
        end else begin
            s1_valid  <= rd_en;
            rsp_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        s1_kind <= rd_kind;
        s1_tag  <= rd_tag;
        if (rd_kind == gnn_pkg::acc_nbr) begin
            s1_data <= gnn_pkg::fv_w'(nbr_list[rd_addr]);
        end else begin
            s1_data <= gnn_pkg::fv_w'(node_tab[rd_addr[gnn_pkg::node_id_w-1:0]]);
        end
        rsp_tag <= s1_tag;
        // second stage looks up the feature or passes the entry through
        rsp_data <= (s1_kind == gnn_pkg::acc_nbr) ?
                    feat[s1_data[gnn_pkg::node_id_w-1:0]] : s1_data;
    end

endmodule

/* hdl/task_dispatch.sv */
// node task dispatcher
`timescale 1ns/1ps
module task_dispatch (
    input  logic                            clk,
    input  logic                            arst_n,
    input  logic                            start,
    input  logic [gnn_pkg::node_cnt_w-1:0]  num_nodes,
    input  logic [gnn_pkg::num_edge_pe-1:0] pe_idle,
    output logic [gnn_pkg::num_edge_pe-1:0] task_valid,
    output logic [gnn_pkg::node_id_w-1:0]   task_node,
    output logic                            done
);

    logic [gnn_pkg::node_cnt_w-1:0]  next_id;  // next node to hand out
    logic                            active;
    logic [gnn_pkg::num_edge_pe-1:0] free;
    logic [gnn_pkg::num_edge_pe-1:0] pick;
    logic                            exhausted;
    logic                            issue;

    assign free      = pe_idle & ~task_valid;  // skip PE given a task last cycle
    assign pick      = free & (~free + 1'b1);  // lowest set bit
    assign exhausted = (next_id == num_nodes);
    assign issue     = active && !exhausted && (pick != '0);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            active     <= 1'b0;
            done       <= 1'b0;
            next_id    <= '0;
            task_valid <= '0;
        end else if (start) begin
            next_id    <= '0;
            task_valid <= '0;
            active     <= (num_nodes != '0);
            done       <= (num_nodes == '0);  // empty run ends at once
        end else begin
            task_valid <= issue ? pick : '0;
            if (issue) begin
                next_id <= next_id + 1'b1;
            end
            // all handed out, every PE back to idle, nothing in flight
            if (active && exhausted && (&pe_idle) && task_valid == '0) begin
                active <= 1'b0;
                done   <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            task_node <= next_id[gnn_pkg::node_id_w-1:0];
        end
    end

endmodule

/* hdl/edge_pe.sv */
// edge aggregation PE
`timescale 1ns/1ps
module edge_pe #(
    parameter logic [gnn_pkg::pe_idx_w-1:0] pe_tag = '0
) (
    input  logic                           clk,
    input  logic                           arst_n,
    input  logic                           task_valid,
    input  logic [gnn_pkg::node_id_w-1:0]  task_node,
    input  logic [gnn_pkg::weight_w-1:0]   weight,
    input  logic                           mem_gnt,
    input  logic                           rsp_valid,
    input  logic [gnn_pkg::pe_idx_w-1:0]   rsp_tag,
    input  logic [gnn_pkg::fv_w-1:0]       rsp_data,
    input  logic                           wb_gnt,
    output logic                           pe_idle,
    output logic                           mem_req,
    output logic                           mem_kind,
    output logic [gnn_pkg::nbr_addr_w-1:0] mem_addr,
    output logic                           wb_req,
    output logic [gnn_pkg::node_id_w-1:0]  wb_node,
    output logic [gnn_pkg::res_w-1:0]      wb_result
);

    typedef enum logic [2:0] {
        st_idle, st_tab_req, st_tab_wait, st_nbr_req, st_nbr_wait, st_scale, st_wback
    } state_t;

    state_t                         state;
    logic [gnn_pkg::nbr_addr_w-1:0] nbr_ptr;   // walks the neighbor list
    logic [gnn_pkg::deg_w-1:0]      deg_left;
    logic [gnn_pkg::sum_w-1:0]      acc;
    logic                           my_rsp;

    assign my_rsp   = rsp_valid && (rsp_tag == pe_tag);  // ignore other PEs' data
    assign pe_idle  = (state == st_idle);
    assign mem_req  = (state == st_tab_req) || (state == st_nbr_req);
    assign mem_kind = (state == st_nbr_req) ? gnn_pkg::acc_nbr : gnn_pkg::acc_node;
    assign mem_addr = (state == st_nbr_req) ? nbr_ptr :
                      {{(gnn_pkg::nbr_addr_w-gnn_pkg::node_id_w){1'b0}}, wb_node};
    assign wb_req   = (state == st_wback);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle:     if (task_valid) state <= st_tab_req;
                st_tab_req:  if (mem_gnt) state <= st_tab_wait;
                st_tab_wait: if (my_rsp) begin
                    // degree 0 goes straight to write-back
                    state <= (rsp_data[gnn_pkg::deg_w-1:0] == '0) ? st_wback : st_nbr_req;
                end
                st_nbr_req:  if (mem_gnt) state <= st_nbr_wait;
                st_nbr_wait: if (my_rsp) begin
                    state <= (deg_left == 1) ? st_scale : st_nbr_req;  // last neighbor
                end
                st_scale:    state <= st_wback;
                st_wback:    if (wb_gnt) state <= st_idle;
                default:     state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            st_idle: if (task_valid) wb_node <= task_node;  // kept until write-back
            st_tab_wait: if (my_rsp) begin
                nbr_ptr   <= rsp_data[gnn_pkg::entry_w-1:gnn_pkg::deg_w];
                deg_left  <= rsp_data[gnn_pkg::deg_w-1:0];
                acc       <= '0;
                wb_result <= '0;
            end
            st_nbr_wait: if (my_rsp) begin
                acc      <= acc + gnn_pkg::sum_w'(rsp_data);
                nbr_ptr  <= nbr_ptr + 1'b1;
                deg_left <= deg_left - 1'b1;
            end
            st_scale: wb_result <= gnn_pkg::res_w'(acc) * gnn_pkg::res_w'(weight);
            default: ;
        endcase
    end

endmodule

/* hdl/gnn_top.sv */
// gnn aggregation engine top
`timescale 1ns/1ps
module gnn_top (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic                          cyc,
    input  logic                          stb,
    input  logic                          we,
    input  logic [gnn_pkg::wb_addr_w-1:0] adr,
    input  logic [gnn_pkg::wb_data_w-1:0] dat_w,
    output logic [gnn_pkg::wb_data_w-1:0] dat_r,
    output logic                          ack,
    output logic                          task_complete
);

    logic                                               start;
    logic [gnn_pkg::node_cnt_w-1:0]                     num_nodes;
    logic [gnn_pkg::weight_w-1:0]                       weight;
    logic                                               host_we;
    logic [1:0]                                         host_sel;
    logic [gnn_pkg::nbr_addr_w-1:0]                     host_addr;
    logic [gnn_pkg::fv_w-1:0]                           host_data;
    logic [gnn_pkg::num_edge_pe-1:0]                    task_valid;
    logic [gnn_pkg::node_id_w-1:0]                      task_node;
    logic [gnn_pkg::num_edge_pe-1:0]                    pe_idle;
    logic [gnn_pkg::num_edge_pe-1:0]                    mem_req;
    logic [gnn_pkg::num_edge_pe-1:0]                    mem_gnt;
    logic [gnn_pkg::num_edge_pe-1:0]                    mem_kind;
    logic [gnn_pkg::nbr_addr_w-1:0]                     mem_addr [gnn_pkg::num_edge_pe];
    logic [gnn_pkg::num_edge_pe-1:0]                    wb_req;
    logic [gnn_pkg::num_edge_pe-1:0]                    wb_gnt;
    logic [gnn_pkg::num_edge_pe*gnn_pkg::node_id_w-1:0] all_wb_node;
    logic [gnn_pkg::num_edge_pe*gnn_pkg::res_w-1:0]     all_wb_result;
    logic                                               rd_en;
    logic                                               rd_kind;
    logic [gnn_pkg::nbr_addr_w-1:0]                     rd_addr;
    logic [gnn_pkg::pe_idx_w-1:0]                       rd_tag;
    logic                                               rsp_valid;
    logic [gnn_pkg::pe_idx_w-1:0]                       rsp_tag;
    logic [gnn_pkg::fv_w-1:0]                           rsp_data;

    // granted PE drives the memory port, its index is the tag
    assign rd_en = |mem_gnt;
    always_comb begin
        rd_kind = gnn_pkg::acc_node;
        rd_addr = '0;
        rd_tag  = '0;
        for (int i = 0; i < gnn_pkg::num_edge_pe; i++) begin
            if (mem_gnt[i]) begin
                rd_kind = mem_kind[i];
                rd_addr = mem_addr[i];
                rd_tag  = gnn_pkg::pe_idx_w'(i);
            end
        end
    end

    gnn_regs i_gnn_regs (
        .clk(clk), .arst_n(arst_n),
        .cyc(cyc), .stb(stb), .we(we), .adr(adr), .dat_w(dat_w),
        .wb_gnt(wb_gnt), .all_wb_node(all_wb_node), .all_wb_result(all_wb_result),
        .done_in(task_complete),
        .dat_r(dat_r), .ack(ack), .start(start),
        .num_nodes(num_nodes), .weight(weight),
        .busy(),                                  // only seen through status reads
        .host_we(host_we), .host_sel(host_sel),
        .host_addr(host_addr), .host_data(host_data)
    );

    graph_mem i_graph_mem (
        .clk(clk), .arst_n(arst_n),
        .host_we(host_we), .host_sel(host_sel), .host_addr(host_addr), .host_data(host_data),
        .rd_en(rd_en), .rd_kind(rd_kind), .rd_addr(rd_addr), .rd_tag(rd_tag),
        .rsp_valid(rsp_valid), .rsp_tag(rsp_tag), .rsp_data(rsp_data)
    );

    task_dispatch i_task_dispatch (
        .clk(clk), .arst_n(arst_n),
        .start(start), .num_nodes(num_nodes), .pe_idle(pe_idle),
        .task_valid(task_valid), .task_node(task_node), .done(task_complete)
    );

    for (genvar i = 0; i < gnn_pkg::num_edge_pe; i++) begin : g_pe
        edge_pe #(.pe_tag(gnn_pkg::pe_idx_w'(i))) i_edge_pe (
            .clk(clk), .arst_n(arst_n),
            .task_valid(task_valid[i]), .task_node(task_node), .weight(weight),
            .mem_gnt(mem_gnt[i]),
            .rsp_valid(rsp_valid), .rsp_tag(rsp_tag), .rsp_data(rsp_data),
            .wb_gnt(wb_gnt[i]),
            .pe_idle(pe_idle[i]),
            .mem_req(mem_req[i]), .mem_kind(mem_kind[i]), .mem_addr(mem_addr[i]),
            .wb_req(wb_req[i]),
            .wb_node(all_wb_node[i*gnn_pkg::node_id_w +: gnn_pkg::node_id_w]),
            .wb_result(all_wb_result[i*gnn_pkg::res_w +: gnn_pkg::res_w])
        );
    end

    rr_arbiter #(.num_reqs(gnn_pkg::num_edge_pe)) mem_arb (
        .clk(clk), .arst_n(arst_n), .reqs(mem_req), .grants(mem_gnt)
    );

    rr_arbiter #(.num_reqs(gnn_pkg::num_edge_pe)) wb_arb (
        .clk(clk), .arst_n(arst_n), .reqs(wb_req), .grants(wb_gnt)
    );

endmodule

/* verification/tb_gnn_tasks.svh */
// wishbone and directed test tasks

    // one classic cycle with the request held until ack
    task automatic wb_access(logic w, logic [11:0] a, logic [31:0] d, output logic [31:0] q);
        int n;
        @(posedge clk);
        cyc   <= 1'b1;
        stb   <= 1'b1;
        we    <= w;
        adr   <= a;
        dat_w <= d;
        n = 0;
        @(negedge clk);  // sample away from the edge
        while (!ack && n < ack_limit) begin
            @(negedge clk);
            n++;
        end
        assert (ack) else begin
            $display("no ack from the DUT for address %03h", a);
            errors++;
        end
        ack_wait = n;
        q        = dat_r;  // read data comes with ack
        @(posedge clk);
        cyc <= 1'b0;
        stb <= 1'b0;
        we  <= 1'b0;
        @(negedge clk);
        ack_late = ack;
    endtask

    task automatic wb_write(logic [11:0] a, logic [31:0] d);
        logic [31:0] unused;
        wb_access(1'b1, a, d, unused);
    endtask

    task automatic wb_read(logic [11:0] a, output logic [31:0] q);
        wb_access(1'b0, a, 32'h0, q);
    endtask

    task automatic test_registers();
        logic [31:0] q;
        logic [11:0] zero_adr [6];
        zero_adr = '{12'h000, 12'h004, 12'h0ff, 12'h105, 12'h440, 12'h800};
        wb_read(gnn_pkg::reg_status, q);
        check_value("registers status", 32'h0, q);
        check_value("registers task_complete", 32'h0, 32'(task_complete));
        check_value("registers ack delay", 32'h1, ack_wait);   // one cycle after request
        check_value("registers ack length", 32'h0, 32'(ack_late));
        set_num_nodes(37);
        wb_read(gnn_pkg::reg_num_nodes, q);
        check_value("registers num_nodes", 32'd37, q);
        set_weight(8'h5a);
        wb_read(gnn_pkg::reg_weight, q);
        check_value("registers weight", 32'h5a, q);
        foreach (zero_adr[i]) begin
            wb_read(zero_adr[i], q);  // ctrl, write-only and unmapped
            check_value($sformatf("registers read %03h", zero_adr[i]), 32'h0, q);
        end
    endtask

    task automatic test_single_node();
        logic [31:0] q;
        set_node(0, 8'd10, 4'd3);
        set_nbr(10, 6'd1);
        set_nbr(11, 6'd2);
        set_nbr(12, 6'd3);
        set_feat(1, 16'd100);
        set_feat(2, 16'd200);
        set_feat(3, 16'd300);
        set_weight(8'd1);
        set_num_nodes(1);
        start_run();
        wait_done("single node");
        wb_read(gnn_pkg::base_res, q);
        check_value("single node", 32'd600, q);  // plain sum
    endtask

    task automatic test_random_graph();
        for (int n = 0; n < 40; n++) begin
            set_node(n, 8'($urandom_range(255)), 4'($urandom_range(15)));
        end
        for (int i = 0; i < 256; i++) begin
            set_nbr(i, 6'($urandom_range(63)));
        end
        for (int n = 0; n < 64; n++) begin
            set_feat(n, 16'($urandom()));
        end
        set_weight(8'($urandom_range(255, 1)));
        set_num_nodes(40);
        start_run();
        wait_done("random graph");
        check_results("random graph", 40);
    endtask

    task automatic test_degree_zero();
        logic [31:0] q;
        int          zero_nodes [4];
        zero_nodes = '{0, 5, 17, 39};
        foreach (zero_nodes[i]) begin
            set_node(zero_nodes[i], ref_start[zero_nodes[i]], 4'd0);
        end
        start_run();  // same 40 nodes
        wait_done("degree zero");
        foreach (zero_nodes[i]) begin
            wb_read(gnn_pkg::base_res + 12'(zero_nodes[i]), q);
            check_value($sformatf("degree zero node %0d", zero_nodes[i]), 32'h0, q);
        end
        check_results("degree zero", 40);
    endtask

    task automatic test_restart();
        logic [31:0] q;
        set_weight((ref_weight + 8'd37) | 8'h01);  // differs from the old weight
        start_run();
        wb_read(gnn_pkg::reg_status, q);
        check_value("restart status in run", 32'h1, q);  // busy, done cleared
        check_value("restart task_complete in run", 32'h0, 32'(task_complete));
        wait_done("restart");
        check_value("restart task_complete at done", 32'h1, 32'(task_complete));
        check_results("restart", 40);
    endtask

    task automatic test_empty_run();
        logic [31:0] q;
        set_num_nodes(0);
        wb_write(gnn_pkg::reg_weight, {24'h0, ~ref_weight});  // any recompute would show
        start_run();
        wb_read(gnn_pkg::reg_status, q);
        check_value("empty run status", 32'h2, q);  // done right away
        check_value("empty run task_complete", 32'h1, 32'(task_complete));
        check_results("empty run", 40);  // results of the last run stay
    endtask

/* verification/tb_gnn_top.sv */
// gnn engine testbench
`timescale 1ns/1ps
module tb_gnn_top;

    localparam int ack_limit  = 16;    // cycles to wait for ack
    localparam int poll_limit = 4000;  // status reads before giving up

    logic        clk;
    logic        arst_n;
    logic        cyc;
    logic        stb;
    logic        we;
    logic [11:0] adr;
    logic [31:0] dat_w;
    logic [31:0] dat_r;
    logic        ack;
    logic        task_complete;

    int          errors;
    int          ack_wait;   // request to ack, last access
    logic        ack_late;   // ack seen one cycle after it came

    // reference copy of the graph
    logic [7:0]  ref_start [64];
    logic [3:0]  ref_deg   [64];
    logic [5:0]  ref_nbr   [256];
    logic [15:0] ref_feat  [64];
    logic [7:0]  ref_weight;

    gnn_top i_gnn_top (
        .clk(clk), .arst_n(arst_n),
        .cyc(cyc), .stb(stb), .we(we), .adr(adr), .dat_w(dat_w),
        .dat_r(dat_r), .ack(ack), .task_complete(task_complete)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;  // 20 ns period
    end

    task automatic check_value(string name, logic [31:0] exp, logic [31:0] act);
        assert (exp === act) else begin
            $display("Mismatch in %s: expected %0h, got %0h", name, exp, act);
            errors++;
        end
    endtask

    // sum of neighbor features times weight
    function automatic logic [27:0] expected_result(int node);
        logic [27:0] sum;
        logic [7:0]  ptr;
        sum = '0;
        ptr = ref_start[node];
        for (int j = 0; j < int'(ref_deg[node]); j++) begin
            sum = sum + 28'(ref_feat[ref_nbr[ptr]]);
            ptr = ptr + 8'd1;  // list index wraps at 256
        end
        return sum * 28'(ref_weight);  // 28 bit product
    endfunction

    task automatic set_node(int n, logic [7:0] st, logic [3:0] d);
        ref_start[n] = st;
        ref_deg[n]   = d;
        wb_write(gnn_pkg::base_node + 12'(n), {20'h0, st, d});  // {start, degree}
    endtask

    task automatic set_nbr(int i, logic [5:0] id);
        ref_nbr[i] = id;
        wb_write(gnn_pkg::base_nbr + 12'(i), {26'h0, id});
    endtask

    task automatic set_feat(int n, logic [15:0] v);
        ref_feat[n] = v;
        wb_write(gnn_pkg::base_fv + 12'(n), {16'h0, v});
    endtask

    task automatic set_weight(logic [7:0] w);
        ref_weight = w;
        wb_write(gnn_pkg::reg_weight, {24'h0, w});
    endtask

    task automatic set_num_nodes(int n);
        wb_write(gnn_pkg::reg_num_nodes, n);
    endtask

    task automatic start_run();
        wb_write(gnn_pkg::reg_ctrl, 32'h1);  // start pulse
    endtask

    // poll status until done, bounded
    task automatic wait_done(string name);
        logic [31:0] st;
        int          polls;
        polls = 0;
        st    = '0;
        while (!st[1] && polls < poll_limit) begin
            wb_read(gnn_pkg::reg_status, st);
            polls++;
        end
        assert (st[1]) else begin
            $display("%s: run did not finish within %0d status reads", name, poll_limit);
            errors++;
        end
        check_value({name, " busy at done"}, 32'h0, 32'(st[0]));
    endtask

    task automatic check_results(string name, int count);
        logic [31:0] got;
        for (int n = 0; n < count; n++) begin
            wb_read(gnn_pkg::base_res + 12'(n), got);
            check_value($sformatf("%s node %0d", name, n), 32'(expected_result(n)), got);
        end
    endtask

    `include "tb_gnn_tasks.svh"

    initial begin
        arst_n   = 1'b0;
        cyc      = 1'b0;
        stb      = 1'b0;
        we       = 1'b0;
        adr      = '0;
        dat_w    = '0;
        errors   = 0;
        ack_wait = 0;
        ack_late = 1'b0;
        void'($urandom(32'ha94eb085));  // one seed for the whole run
        repeat (3) @(posedge clk);
        arst_n <= 1'b1;
        test_registers();
        test_single_node();
        test_random_graph();
        test_degree_zero();
        test_restart();
        test_empty_run();
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

/* list.f */
+incdir+verification
hdl/gnn_pkg.sv
hdl/rr_arbiter.sv
hdl/gnn_regs.sv
hdl/graph_mem.sv
hdl/task_dispatch.sv
hdl/edge_pe.sv
hdl/gnn_top.sv
verification/tb_gnn_top.sv

/* run_sim.sh */
#!/bin/sh
# build and run the gnn engine testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_gnn_top -Mdir obj_dir -f list.f
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/Vtb_gnn_top > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

# the testbench prints the pass line only when every check held
if grep -qF '** PASS **' "$log"; then
    exit 0
fi
exit 1
